// ==== mouse_trace.f ====
design/mouse_trace_pkg.sv
design/tcb_capture.sv
design/trace_collect.sv
design/trace_fifo.sv
design/mouse_trace_top.sv
verification/mouse_trace_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the trace unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=build
sim_bin=mouse_trace_sim
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f mouse_trace.f \
    --top-module mouse_trace_tb \
    --Mdir "$build_dir" \
    -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

// ==== verification/mouse_trace_tb.sv ====
/* directed testbench of the trace unit that plays the core on the TCB bus
   and checks every retired-instruction record against its own model */
`default_nettype none

module mouse_trace_tb
    import mouse_trace_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned DEPTH = 8;
    localparam int          tmo_c = 50;  // cycles allowed per wait

    logic       tcb = 1'b0;
    logic       rst;
    logic       bus_vld;
    logic       bus_rdy;
    tcb_req_t   bus_req;
    tcb_rsp_t   bus_rsp;
    pha_t       pha;
    logic       rec_pop;
    trace_rec_t rec;
    logic       rec_emp;
    logic       rec_ovf;

    logic [31:0] lcg_q = 32'h7699_10be;  // random state
    trace_rec_t  exp_q [$];              // emitted records, oldest first
    trace_rec_t  exp_cur;                // model of the open record
    logic        exp_open;
    logic [15:0] exp_seq;
    int          err_cnt;
    int          err_mark;               // errors before the running test
    int          test_cnt;

    always #4 tcb = ~tcb;  // 8 ns

    mouse_trace_top #(
        .DEPTH (DEPTH)
    ) dut (
        .tcb     (tcb),
        .rst     (rst),
        .bus_vld (bus_vld),
        .bus_rdy (bus_rdy),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .pha     (pha),
        .rec_pop (rec_pop),
        .rec     (rec),
        .rec_emp (rec_emp),
        .rec_ovf (rec_ovf)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
        return lcg_q;
    endfunction

    // register file region with the GPR index in bits 6 to 2
    function automatic logic [31:0] gpr_adr(input logic [4:0] idx);
        return {25'h1ff_ffff, idx, 2'b00};
    endfunction

    function automatic int stall(input logic ws);
        return ws ? int'(lcg_next() % 32'd3) : 0;  // bus_rdy low cycles
    endfunction

    task automatic cycle();
        @(posedge tcb);
        #1;  // drive point
    endtask

    task automatic idle(input int n);
        bus_vld = 1'b0;
        bus_rdy = 1'b0;
        repeat (n) cycle();
    endtask

    task automatic gap(input logic ws);
        if (ws) begin
            idle(int'(lcg_next() % 32'd3));
        end
    endtask

    // one request held until bus_rdy with its response in the next cycle
    task automatic bus_xfer(input pha_t p, input logic wen, input logic [31:0] adr,
                            input logic [1:0] siz, input logic [31:0] wdt,
                            input logic [31:0] rdt, input int waits);
        bus_vld         = 1'b1;
        pha             = p;
        bus_req.wen     = wen;
        bus_req.adr.mem = adr;
        bus_req.siz     = siz;
        bus_req.ben     = 4'hf;
        bus_req.wdt     = wdt;
        for (int i = 0; i < waits; i++) begin
            bus_rdy = 1'b0;
            cycle();
        end
        bus_rdy = 1'b1;
        cycle();            // transfer edge
        bus_vld     = 1'b0;
        bus_rdy     = 1'b0;
        bus_rsp.rdt = rdt;  // response cycle
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // core model
    ////////////////////////////////////////////////////////////////////////////

    // fetch closes the open record, then opens the next one
    task automatic fetch(input logic ws);
        logic [31:0] pc;
        logic [31:0] ins;
        pc  = lcg_next() & 32'hffff_fffc;
        ins = lcg_next() | 32'h0000_0003;  // 32 bit encoding
        if (exp_open) begin
            exp_cur.seq = exp_seq;
            exp_q.push_back(exp_cur);
            exp_seq++;  // counts dropped records too
        end
        exp_cur         = '0;
        exp_cur.ifu_adr = pc;
        exp_cur.ifu_ins = ins;
        exp_open        = 1'b1;
        gap(ws);
        bus_xfer(pha_if, 1'b0, pc, 2'd2, 32'h0, ins, stall(ws));
    endtask

    task automatic read_reg(input pha_t p, input logic ws);
        gap(ws);
        bus_xfer(p, 1'b0, gpr_adr(5'(lcg_next())), 2'd2, 32'h0, lcg_next(), stall(ws));
    endtask

    task automatic wback(input logic [4:0] rd, input logic [31:0] dat, input logic ws);
        gap(ws);
        bus_xfer(pha_wb, 1'b1, gpr_adr(rd), 2'd2, dat, lcg_next(), stall(ws));
        exp_cur.wbu_ena = 1'b1;
        exp_cur.wbu_idx = rd;
        exp_cur.wbu_dat = dat;
    endtask

    // kind 0 alu, 1 load, 2 store, 3 branch
    task automatic body(input int kind, input logic ws);
        logic [31:0] adr;
        logic [31:0] dat;
        logic [1:0]  siz;
        adr = lcg_next();
        dat = lcg_next();
        siz = 2'(lcg_next() % 32'd3);  // byte, half or word
        read_reg(pha_rs1, ws);
        if (kind != 1) begin
            read_reg(pha_rs2, ws);  // load has no rs2
        end
        case (kind)
            0: wback(5'(lcg_next()), lcg_next(), ws);
            1: begin
                gap(ws);
                bus_xfer(pha_mld, 1'b0, adr, siz, 32'h0, dat, stall(ws));
                exp_cur.lsu_ena = 1'b1;
                exp_cur.lsu_ren = 1'b1;
                exp_cur.lsu_rid = adr[6:2];  // GPR index bits of the address
                exp_cur.lsu_adr = adr;
                exp_cur.lsu_siz = siz;
                exp_cur.lsu_rdt = dat;       // data of the response cycle
                wback(5'(lcg_next()), dat, ws);
            end
            2: begin
                gap(ws);
                bus_xfer(pha_mst, 1'b1, adr, siz, dat, lcg_next(), stall(ws));
                exp_cur.lsu_ena = 1'b1;
                exp_cur.lsu_wen = 1'b1;
                exp_cur.lsu_adr = adr;
                exp_cur.lsu_siz = siz;
                exp_cur.lsu_wdt = dat;
            end
            default: begin  // branch compare leaves no trace
                gap(ws);
                bus_xfer(pha_exe, 1'b0, adr, 2'd2, 32'h0, lcg_next(), stall(ws));
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_rec(input string name, input trace_rec_t got, input trace_rec_t want);
        if (got !== want) begin
            err_cnt++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            err_cnt++;
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, want);
        end
    endtask

    // wait for the head, compare it with the model, then pop it
    task automatic pop_check();
        trace_rec_t want;
        int         n;
        n = 0;
        while (rec_emp && n < tmo_c) begin
            cycle();
            n++;
        end
        if (rec_emp) begin
            err_cnt++;
            $display("timeout at %0t: no trace record within %0d cycles", $time, tmo_c);
        end else if (exp_q.size() == 0) begin
            err_cnt++;
            $display("trace record at %0t that the model does not expect", $time);
        end else begin
            want = exp_q.pop_front();
            check_rec("rec", rec, want);
            rec_pop = 1'b1;
            cycle();
            rec_pop = 1'b0;
        end
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_mark) ? "ok" : "errors");
        err_mark = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic alu_test();
        fetch(1'b0);                           // first fetch has nothing to close
        idle(3);
        check_flag("rec_emp", rec_emp, 1'b1);
        body(0, 1'b0);
        fetch(1'b0);
        check_flag("rec_emp", rec_emp, 1'b1);  // just after the fetch edge
        cycle();
        check_flag("rec_emp", rec_emp, 1'b1);  // push only registered
        cycle();
        check_flag("rec_emp", rec_emp, 1'b0);  // record visible after the second edge
        pop_check();                           // seq 0
        check_flag("rec_emp", rec_emp, 1'b1);
        report_test("alu instruction");
    endtask

    task automatic load_store_test();
        body(1, 1'b0);
        fetch(1'b0);
        body(2, 1'b0);
        fetch(1'b0);
        repeat (2) pop_check();
        report_test("load and store");
    endtask

    task automatic wait_state_test();
        for (int k = 0; k < 8; k++) begin
            body(k % 4, 1'b1);  // stalls and idles with branch stalls in execute
            fetch(1'b1);
        end
        repeat (8) pop_check();
        report_test("wait states");
    endtask

    task automatic order_test();
        for (int k = 0; k < 6; k++) begin
            body((k * 3) % 4, 1'b0);
            fetch(1'b0);
        end
        idle(2);
        repeat (6) pop_check();
        check_flag("rec_emp", rec_emp, 1'b1);
        check_flag("rec_ovf", rec_ovf, 1'b0);
        report_test("ordering");
    endtask

    task automatic overflow_test();
        for (int k = 0; k < int'(DEPTH) + 3; k++) begin
            body(k % 4, 1'b0);
            fetch(1'b0);
        end
        idle(2);
        check_flag("rec_ovf", rec_ovf, 1'b1);
        repeat (3) exp_q.delete(exp_q.size() - 1);  // last three find the FIFO full
        repeat (DEPTH) pop_check();
        check_flag("rec_emp", rec_emp, 1'b1);
        body(0, 1'b0);
        fetch(1'b0);
        pop_check();                                // seq jumps by the dropped three
        check_flag("rec_ovf", rec_ovf, 1'b1);
        check_flag("rec_emp", rec_emp, 1'b1);
        report_test("overflow");
    endtask

    initial begin
        rst      = 1'b1;
        bus_vld  = 1'b0;
        bus_rdy  = 1'b0;
        bus_req  = '0;
        bus_rsp  = '0;
        pha      = pha_if;
        rec_pop  = 1'b0;
        exp_cur  = '0;
        exp_open = 1'b0;
        exp_seq  = '0;
        err_cnt  = 0;
        err_mark = 0;
        test_cnt = 0;
        repeat (10) @(posedge tcb);
        #1;
        rst = 1'b0;
        check_flag("rec_emp", rec_emp, 1'b1);
        check_flag("rec_ovf", rec_ovf, 1'b0);
        alu_test();
        load_store_test();
        wait_state_test();
        order_test();
        overflow_test();
        $display("tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/mouse_trace_top.sv ====
/* execution trace unit for the multi-cycle RISC-V core, watches the TCB bus
   and the core phase, offers retired-instruction records to a reader */
`default_nettype none

module mouse_trace_top
    import mouse_trace_pkg::*;
#(
    parameter int unsigned DEPTH = 8  // record FIFO depth, power of two
)(
    // system
    input  logic       tcb,
    input  logic       rst,
    // monitored bus, never driven from here
    input  logic       bus_vld,
    input  logic       bus_rdy,
    input  tcb_req_t   bus_req,
    input  tcb_rsp_t   bus_rsp,
    input  pha_t       pha,
    // reader
    input  logic       rec_pop,
    output trace_rec_t rec,
    output logic       rec_emp,
    output logic       rec_ovf
);

    logic       xfer_vld;  // capture to collector
    xfer_t      xfer;
    logic       rec_push;  // collector to FIFO
    trace_rec_t rec_in;

    // bus request paired with its response
    tcb_capture u_capture (
        .tcb      (tcb),
        .rst      (rst),
        .bus_vld  (bus_vld),
        .bus_rdy  (bus_rdy),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .pha      (pha),
        .xfer_vld (xfer_vld),
        .xfer     (xfer)
    );

    // transfers to records
    trace_collect u_collect (
        .tcb      (tcb),
        .rst      (rst),
        .xfer_vld (xfer_vld),
        .xfer     (xfer),
        .rec_push (rec_push),
        .rec_in   (rec_in)
    );

    trace_fifo #(
        .DEPTH (DEPTH)
    ) u_fifo (
        .tcb      (tcb),
        .rst      (rst),
        .rec_push (rec_push),
        .rec_in   (rec_in),
        .rec_pop  (rec_pop),
        .rec      (rec),
        .rec_emp  (rec_emp),
        .rec_ovf  (rec_ovf)
    );

endmodule

`default_nettype wire

// ==== design/trace_fifo.sv ====
/* record FIFO between collector and the external reader, head is shown
   without a pop, overflow drops the new record and is flagged until reset */
`default_nettype none

module trace_fifo
    import mouse_trace_pkg::*;
#(
    parameter int unsigned DEPTH = 8  // power of two
)(
    // system
    input  logic       tcb,
    input  logic       rst,
    // write side
    input  logic       rec_push,
    input  trace_rec_t rec_in,
    // read side
    input  logic       rec_pop,   // strobe, removes the head
    output trace_rec_t rec,       // head, valid while !rec_emp
    output logic       rec_emp,
    output logic       rec_ovf    // sticky
);

    ////////////////////////////////////////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned aw = $clog2(DEPTH);

    trace_rec_t  mem [DEPTH];  // record storage
    logic [aw:0] wr_ptr;       // extra bit tells full from empty
    logic [aw:0] rd_ptr;
    logic        full;
    logic        pop_ok;       // pop that really removes a record
    logic        push_ok;      // push that really stores

    assign rec_emp = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr == {~rd_ptr[aw], rd_ptr[aw-1:0]});
    assign pop_ok  = rec_pop && !rec_emp;
    // full with a pop frees the head slot at the same edge
    assign push_ok = rec_push && (!full || pop_ok);

    assign rec = mem[rd_ptr[aw-1:0]];  // fall-through head

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge tcb) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            rec_ovf <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rec_push && !push_ok) begin
                rec_ovf <= 1'b1;  // record lost, stays set
            end
        end
    end

    // write port
    always_ff @(posedge tcb) begin
        if (push_ok) begin
            mem[wr_ptr[aw-1:0]] <= rec_in;
        end
    end

    // reader must look at rec_emp first
    a_pop_emp: assert property (@(posedge tcb) disable iff (rst)
        rec_pop |-> !rec_emp)
    else $error("trace record popped while FIFO is empty");

endmodule

`default_nettype wire

// ==== design/trace_collect.sv ====
/* builds one trace record per retired instruction from the stream of bus
   transfers, a record is closed and pushed out when the next fetch arrives */
`default_nettype none

module trace_collect
    import mouse_trace_pkg::*;
(
    // system
    input  logic       tcb,
    input  logic       rst,
    // from capture
    input  logic       xfer_vld,
    input  xfer_t      xfer,
    // to FIFO
    output logic       rec_push,  // one cycle strobe
    output trace_rec_t rec_in     // valid with rec_push
);

    ////////////////////////////////////////////////////////////////////////////
    // local signals
    ////////////////////////////////////////////////////////////////////////////

    logic        xfer_fch;  // fetch transfer in this cycle
    logic        rec_opn;   // a record is being built
    logic [15:0] seq_cnt;   // number of the next emitted record
    trace_rec_t  rec_cur;   // open record
    trace_rec_t  rec_nxt;   // open record after this transfer
    trace_rec_t  rec_out;   // open record as it leaves, numbered

    assign xfer_fch = xfer_vld && (xfer.pha == pha_if);

    ////////////////////////////////////////////////////////////////////////////
    // record update
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rec_nxt = rec_cur;  // rs1, rs2 and execute leave no trace
        case (xfer.pha)
            pha_if: begin
                // fresh record, no write-back nor load/store yet
                rec_nxt         = '0;
                rec_nxt.ifu_adr = xfer.req.adr.mem;
                rec_nxt.ifu_ins = xfer.rdt;
            end
            pha_wb: begin
                rec_nxt.wbu_ena = 1'b1;
                rec_nxt.wbu_idx = xfer.req.adr.gpr.idx;  // register view
                rec_nxt.wbu_dat = xfer.req.wdt;
            end
            pha_mld: begin
                rec_nxt.lsu_ena = 1'b1;
                rec_nxt.lsu_ren = 1'b1;
                rec_nxt.lsu_rid = xfer.req.adr.gpr.idx;
                rec_nxt.lsu_adr = xfer.req.adr.mem;    // memory view, same word
                rec_nxt.lsu_siz = xfer.req.siz;
                rec_nxt.lsu_rdt = xfer.rdt;            // response cycle data
            end
            pha_mst: begin
                rec_nxt.lsu_ena = 1'b1;
                rec_nxt.lsu_wen = 1'b1;
                rec_nxt.lsu_adr = xfer.req.adr.mem;
                rec_nxt.lsu_siz = xfer.req.siz;
                rec_nxt.lsu_wdt = xfer.req.wdt;
            end
            default: begin
            end
        endcase
    end

    // stamp the sequence number on the way out
    always_comb begin
        rec_out     = rec_cur;
        rec_out.seq = seq_cnt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // control and payload registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge tcb) begin
        if (rst) begin
            rec_opn  <= 1'b0;
            rec_push <= 1'b0;
            seq_cnt  <= '0;
        end else begin
            rec_push <= xfer_fch && rec_opn;  // first fetch has nothing to close
            if (xfer_fch) begin
                rec_opn <= 1'b1;
                if (rec_opn) begin
                    seq_cnt <= seq_cnt + 16'd1;  // counts dropped records too
                end
            end
        end
    end

    always_ff @(posedge tcb) begin
        if (xfer_vld) begin
            rec_cur <= rec_nxt;
        end
        if (xfer_fch) begin
            rec_in <= rec_out;
        end
    end

    // a multi-cycle core retires at most one GPR write per instruction
    a_one_wb: assert property (@(posedge tcb) disable iff (rst)
        xfer_vld && (xfer.pha == pha_wb) && rec_opn |-> !rec_cur.wbu_ena)
    else $error("second write-back within one instruction at PC %h", rec_cur.ifu_adr);

endmodule

`default_nettype wire

// ==== design/tcb_capture.sv ====
/* bus monitor front end, pairs each TCB request and its phase with the read
   data of the next cycle and hands the result on as one transfer strobe */
`default_nettype none

module tcb_capture
    import mouse_trace_pkg::*;
(
    // system
    input  logic     tcb,       // bus clock
    input  logic     rst,       // sync reset, active high
    // monitored TCB bus
    input  logic     bus_vld,
    input  logic     bus_rdy,
    input  tcb_req_t bus_req,
    input  tcb_rsp_t bus_rsp,   // valid the cycle after a transfer
    input  pha_t     pha,       // core phase, valid with bus_vld
    // to collector
    output logic     xfer_vld,
    output xfer_t    xfer
);

    ////////////////////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////////////////////

    logic     trn;    // transfer at this edge
    tcb_req_t req_q;  // request held over into the response cycle
    pha_t     pha_q;

    assign trn = bus_vld & bus_rdy;

    // strobe follows the transfer by one edge
    always_ff @(posedge tcb) begin
        if (rst) begin
            xfer_vld <= 1'b0;
        end else begin
            xfer_vld <= trn;
        end
    end

    // payload, only meaningful while xfer_vld
    always_ff @(posedge tcb) begin
        if (trn) begin
            req_q <= bus_req;
            pha_q <= pha;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // response side
    ////////////////////////////////////////////////////////////////////////////

    // read data comes live, this is the only place that knows the latency
    assign xfer.pha = pha_q;
    assign xfer.req = req_q;
    assign xfer.rdt = bus_rsp.rdt;

    // core never issues the spare code
    a_pha_def: assert property (@(posedge tcb) disable iff (rst)
        trn |-> pha inside {pha_if, pha_rs1, pha_rs2, pha_mld, pha_mst, pha_exe, pha_wb})
    else $error("undefined phase code %b on a bus transfer", pha);

endmodule

`default_nettype wire

// ==== design/mouse_trace_pkg.sv ====
/* shared types of the trace unit: TCB bus structs, core phase codes and the
   record of one retired instruction, imported by every module of the design */
`default_nettype none

package mouse_trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned xlen_c = 32;  // data and address width

    // core execution phase, GPR phases have the top bit set
    typedef enum logic [2:0] {
        pha_if  = 3'b000,  // instruction fetch
        pha_mld = 3'b001,  // memory load
        pha_mst = 3'b010,  // memory store
        pha_exe = 3'b011,  // execute, branch condition only
        pha_wb  = 3'b100,  // GPR write-back
        pha_rs1 = 3'b101,  // read rs1
        pha_rs2 = 3'b110   // read rs2
    } pha_t;               // 3'b111 is never issued

    // one address word, seen as memory or as register file access
    typedef union packed {
        logic [xlen_c-1:0] mem;      // raw byte address
        struct packed {
            logic [xlen_c-8:0] rgn;  // region of the register file
            logic [4:0]        idx;  // GPR index
            logic [1:0]        ofs;  // byte offset, always word aligned
        } gpr;
    } tcb_adr_u;

    typedef struct packed {
        logic              wen;  // write enable
        tcb_adr_u          adr;
        logic [1:0]        siz;  // log2 of transfer size in bytes
        logic [3:0]        ben;  // byte enables
        logic [xlen_c-1:0] wdt;  // write data
    } tcb_req_t;

    typedef struct packed {
        logic [xlen_c-1:0] rdt;  // read data, one cycle after the request
    } tcb_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // trace
    ////////////////////////////////////////////////////////////////////////////

    // completed transfer, request joined with its read data
    typedef struct packed {
        pha_t              pha;
        tcb_req_t          req;
        logic [xlen_c-1:0] rdt;
    } xfer_t;

    typedef struct packed {
        logic [15:0]       seq;      // retirement sequence number
        logic [xlen_c-1:0] ifu_adr;  // PC
        logic [xlen_c-1:0] ifu_ins;  // instruction word, always 32 bit
        logic              wbu_ena;  // GPR write-back
        logic [4:0]        wbu_idx;
        logic [xlen_c-1:0] wbu_dat;
        logic              lsu_ena;  // load or store present
        logic              lsu_wen;  // store
        logic              lsu_ren;  // load
        logic [4:0]        lsu_rid;  // load destination, register view of the address
        logic [xlen_c-1:0] lsu_adr;
        logic [1:0]        lsu_siz;
        logic [xlen_c-1:0] lsu_wdt;  // store data
        logic [xlen_c-1:0] lsu_rdt;  // load data
    } trace_rec_t;

endpackage

`default_nettype wire
